//--- sim.f
source/clock_pkg.sv
source/display_pkg.sv
source/tick_gen.sv
source/switch_conditioner.sv
source/clock_controller.sv
source/time_keeper.sv
source/digit_encoder.sv
source/display_scan.sv
source/digital_clock_top.sv
verification/digital_clock_tb.sv

//--- verification/clock_input.txt
// Columns: action count exp_min exp_sec exp_mode exp_alarm, all hex; min and sec as two digits
// Actions: 0 wait count seconds, 1..4 press mode/position/step/alarm count times, 5 check
5 00 00 00 0 0
0 05 00 00 0 0
5 00 00 05 0 0
0 36 00 00 0 0
5 00 00 59 0 0
0 01 00 00 0 0
5 00 01 00 0 0
1 01 00 00 0 0
5 00 01 01 1 0
0 03 00 00 0 0
5 00 01 01 1 0
3 3a 00 00 0 0
5 00 01 59 1 0
3 01 00 00 0 0
5 00 01 00 1 0
2 01 00 00 0 0
3 02 00 00 0 0
5 00 03 00 1 0
1 01 00 00 0 0
5 00 00 00 2 0
3 04 00 00 0 0
2 01 00 00 0 0
3 0a 00 00 0 0
5 00 04 10 2 0
1 01 00 00 0 0
5 00 03 16 0 0
4 01 00 00 0 0
5 00 03 17 0 0
0 34 00 00 0 0
5 00 04 09 0 0
0 01 00 00 0 0
5 00 04 10 0 1
0 05 00 00 0 0
5 00 04 15 0 1
4 01 00 00 0 0
5 00 04 16 0 0

//--- verification/digital_clock_tb.sv
// Digital clock testbench: replays the step file, presses switches and checks the scanned display
module digital_clock_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// Short dividers so a second is 200 cycles
	localparam int TICKS_PER_SEC    = 200;
	localparam int TICKS_PER_SAMPLE = 4;
	localparam int TICKS_PER_SCAN   = 2;
	localparam int CLK_PERIOD       = 40;
	localparam int DRIVE_DELAY      = 2;
	localparam int DIGITS           = display_pkg::DIGIT_COUNT;
	// Four sample periods low, then four high
	localparam int PRESS_CYCLES     = 4 * TICKS_PER_SAMPLE;
	// Phases within a second, counted from the seconds update
	localparam int PRESS_PHASE      = 20;
	localparam int CHECK_PHASE      = TICKS_PER_SEC / 2;
	localparam int MAX_STEPS        = 64;
	localparam int STEP_WORDS       = 6;
	localparam int MARGIN_CYCLES    = 2000;
	localparam logic [7:0] ACT_WAIT  = 8'h00;
	localparam logic [7:0] ACT_CHECK = 8'h05;

	logic                  clk;
	logic                  rst_n;
	logic [3:0]            sw_n;
	display_pkg::segment_t seg;
	logic                  seg_dp;
	logic [DIGITS-1:0]     seg_enb;
	logic                  alarm;

	// Flat step table, STEP_WORDS entries per line
	logic [7:0] step_mem [STEP_WORDS*MAX_STEPS];
	int step_count;
	int limit_cycles;
	logic limit_ready = 1'b0;
	int cyc = 0;
	int checks_run;
	int checks_failed;
	int other_errors;

	// Display contents as read back
	logic [3:0] shown_digit [DIGITS];
	logic [DIGITS-1:0] shown_dp;

	digital_clock_top #(
		.TICKS_PER_SEC    (TICKS_PER_SEC),
		.TICKS_PER_SAMPLE (TICKS_PER_SAMPLE),
		.TICKS_PER_SCAN   (TICKS_PER_SCAN)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_sw_n    (sw_n),
		.o_seg     (seg),
		.o_seg_dp  (seg_dp),
		.o_seg_enb (seg_enb),
		.o_alarm   (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Cycles since reset release, in step with the seconds divider
	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
		end
	end

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	// At least one edge, then on to the given phase of a second
	task automatic advance_to_phase(input int phase);
		@(posedge clk);
		#(DRIVE_DELAY);
		while ((cyc % TICKS_PER_SEC) != phase) begin
			@(posedge clk);
			#(DRIVE_DELAY);
		end
	endtask

	// Crosses exactly that many seconds updates
	task automatic wait_seconds(input int seconds);
		repeat (seconds) advance_to_phase(0);
	endtask

	// One press per second, done well before the next update
	task automatic press_switch(input int idx);
		advance_to_phase(PRESS_PHASE);
		sw_n[idx] = 1'b0;
		repeat (PRESS_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		sw_n[idx] = 1'b1;
		repeat (PRESS_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
	endtask

	// Reverse lookup, 4'hf when nothing matches
	function automatic logic [3:0] digit_of_segments(input display_pkg::segment_t code);
		logic [3:0] digit;
		digit = 4'hf;
		for (int i = 0; i < 10; i++) begin
			if (display_pkg::seg_of_digit(display_pkg::digit_t'(i)) == code)
				digit = 4'(i);
		end
		return digit;
	endfunction

	// Setup lights dot 0, alarm lights dot 1
	function automatic logic [DIGITS-1:0] dots_of_mode(input logic [7:0] mode);
		logic [DIGITS-1:0] dots;
		dots = '0;
		if (mode == 8'h01)
			dots[0] = 1'b1;
		else if (mode == 8'h02)
			dots[1] = 1'b1;
		return dots;
	endfunction

	// Wait for each enable in turn and latch its segments and dot
	task automatic read_display();
		logic [DIGITS-1:0] one_low;
		for (int d = 0; d < DIGITS; d++) begin
			one_low = '1;
			one_low[d] = 1'b0;
			while (seg_enb != one_low) begin
				@(posedge clk);
				#(DRIVE_DELAY);
			end
			shown_digit[d] = digit_of_segments(seg);
			shown_dp[d] = seg_dp;
		end
	endtask

	task automatic check_display(input int step, input logic [7:0] exp_min,
			input logic [7:0] exp_sec, input logic [7:0] exp_mode, input logic [7:0] exp_alarm);
		logic [7:0] got_min;
		logic [7:0] got_sec;
		logic [DIGITS-1:0] exp_dp;
		int fails;
		fails = 0;
		advance_to_phase(CHECK_PHASE);
		read_display();
		got_min = {shown_digit[3], shown_digit[2]};
		got_sec = {shown_digit[1], shown_digit[0]};
		exp_dp = dots_of_mode(exp_mode);
		assert (got_min == exp_min) else begin
			$display("Fail o_seg minutes (step %0d): expected 0x%02h, got 0x%02h",
				step, exp_min, got_min);
			fails++;
		end
		assert (got_sec == exp_sec) else begin
			$display("Fail o_seg seconds (step %0d): expected 0x%02h, got 0x%02h",
				step, exp_sec, got_sec);
			fails++;
		end
		assert (shown_dp == exp_dp) else begin
			$display("Fail o_seg_dp (step %0d): expected 0x%h, got 0x%h", step, exp_dp, shown_dp);
			fails++;
		end
		assert (alarm == exp_alarm[0]) else begin
			$display("Fail o_alarm (step %0d): expected 0x%h, got 0x%h", step, exp_alarm[0], alarm);
			fails++;
		end
		checks_run++;
		if (fails != 0)
			checks_failed++;
		$display("Test %0d (step %0d) %02h:%02h mode %0h: %s", checks_run, step,
			exp_min, exp_sec, exp_mode, (fails == 0) ? "ok" : "mismatch");
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial begin
		logic [7:0] action;
		logic [7:0] count;
		rst_n = 1'b0;
		sw_n = 4'hf;
		checks_run = 0;
		checks_failed = 0;
		other_errors = 0;
		step_count = 0;
		limit_cycles = MARGIN_CYCLES;
		$readmemh("verification/clock_input.txt", step_mem);
		// Unread entries stay unknown; each step lasts at most count+1 seconds
		while (step_count < MAX_STEPS && !$isunknown(step_mem[STEP_WORDS*step_count])) begin
			count = step_mem[STEP_WORDS*step_count + 1];
			limit_cycles += (count + 1) * TICKS_PER_SEC;
			step_count++;
		end
		limit_ready = 1'b1;
		repeat (5) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		if (step_count == 0) begin
			$display("No steps could be read from the data file");
			other_errors++;
		end
		for (int idx = 0; idx < step_count; idx++) begin
			action = step_mem[STEP_WORDS*idx];
			count = step_mem[STEP_WORDS*idx + 1];
			case (action)
				ACT_WAIT: wait_seconds(count);
				ACT_CHECK: check_display(idx, step_mem[STEP_WORDS*idx + 2],
					step_mem[STEP_WORDS*idx + 3], step_mem[STEP_WORDS*idx + 4],
					step_mem[STEP_WORDS*idx + 5]);
				8'h01, 8'h02, 8'h03, 8'h04: repeat (count) press_switch(action - 1);
				default: begin
					$display("Step %0d has an unknown action code 0x%02h", idx, action);
					other_errors++;
				end
			endcase
		end
		$display("Tests run: %0d, mismatched: %0d, other errors: %0d",
			checks_run, checks_failed, other_errors);
		if (checks_failed == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Bound from the summed step lengths
	initial begin
		wait (limit_ready);
		repeat (limit_cycles) @(posedge clk);
		$display("Watchdog: the run did not finish within %0d clock cycles", limit_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- source/digital_clock_top.sv
// Digital clock top: strobe dividers, switch handling, time keeping and display scan
module digital_clock_top #(
	parameter int TICKS_PER_SEC    = 50_000_000,
	parameter int TICKS_PER_SAMPLE = 500_000,
	parameter int TICKS_PER_SCAN   = 5_000
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [3:0]                          i_sw_n,
	output display_pkg::segment_t               o_seg,
	output logic                                o_seg_dp,
	output logic [display_pkg::DIGIT_COUNT-1:0] o_seg_enb,
	output logic                                o_alarm
);

	// Switch bit map
	localparam int SWITCH_COUNT = 4;
	localparam int SW_MODE      = 0;
	localparam int SW_POS       = 1;
	localparam int SW_STEP      = 2;
	localparam int SW_ALARM     = 3;

	logic sec_tick;
	logic sample_tick;
	logic scan_tick;
	logic [SWITCH_COUNT-1:0] press;
	clock_pkg::mode_t mode;
	logic alarm_en;
	logic sec_run;
	logic set_sec;
	logic set_min;
	logic set_alarm_sec;
	logic set_alarm_min;
	clock_pkg::time_field_t show_min;
	clock_pkg::time_field_t show_sec;
	display_pkg::segment_t seg_codes [display_pkg::DIGIT_COUNT];

	// ----------------------------------------------------------
	// Strobe dividers
	// ----------------------------------------------------------
	tick_gen #(.DIVISOR(TICKS_PER_SEC)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIVISOR(TICKS_PER_SAMPLE)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	tick_gen #(.DIVISOR(TICKS_PER_SCAN)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// ----------------------------------------------------------
	// Switches and control
	// ----------------------------------------------------------
	switch_conditioner #(.SWITCH_COUNT(SWITCH_COUNT)) u_switch_conditioner (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_sw_n   (i_sw_n),
		.o_press  (press)
	);

	// Position only steers the step strobes inside the controller
	clock_controller u_clock_controller (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_sec_tick      (sec_tick),
		.i_press_mode    (press[SW_MODE]),
		.i_press_pos     (press[SW_POS]),
		.i_press_step    (press[SW_STEP]),
		.i_press_alarm   (press[SW_ALARM]),
		.o_mode          (mode),
		.o_position      (),
		.o_alarm_en      (alarm_en),
		.o_sec_run       (sec_run),
		.o_set_sec       (set_sec),
		.o_set_min       (set_min),
		.o_set_alarm_sec (set_alarm_sec),
		.o_set_alarm_min (set_alarm_min)
	);

	// ----------------------------------------------------------
	// Time keeping and display
	// ----------------------------------------------------------
	time_keeper u_time_keeper (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_mode          (mode),
		.i_alarm_en      (alarm_en),
		.i_sec_run       (sec_run),
		.i_set_sec       (set_sec),
		.i_set_min       (set_min),
		.i_set_alarm_sec (set_alarm_sec),
		.i_set_alarm_min (set_alarm_min),
		.o_show_min      (show_min),
		.o_show_sec      (show_sec),
		.o_alarm         (o_alarm)
	);

	digit_encoder u_digit_encoder (
		.i_min       (show_min),
		.i_sec       (show_sec),
		.o_seg_codes (seg_codes)
	);

	display_scan u_display_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan      (scan_tick),
		.i_seg_codes (seg_codes),
		.i_mode      (mode),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

//--- source/display_scan.sv
// Display scanner: steps through digits, drives active-low enables, segments and mode dots
module display_scan (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                i_scan,
	input  display_pkg::segment_t               i_seg_codes [display_pkg::DIGIT_COUNT],
	input  clock_pkg::mode_t                    i_mode,
	output display_pkg::segment_t               o_seg,
	output logic                                o_seg_dp,
	output logic [display_pkg::DIGIT_COUNT-1:0] o_seg_enb
);

	localparam display_pkg::digit_sel_t LAST_SEL =
		display_pkg::digit_sel_t'(display_pkg::DIGIT_COUNT - 1);

	display_pkg::digit_sel_t scan_idx;
	display_pkg::digit_sel_t next_idx;
	logic [display_pkg::DIGIT_COUNT-1:0] enb_next;
	logic dp_next;

	// Index for the coming cycle, so outputs line up with it
	always_comb begin
		next_idx = scan_idx;
		if (i_scan) begin
			next_idx = (scan_idx == LAST_SEL) ? '0 : scan_idx + 1'b1;
		end
		// One low enable at a time
		for (int i = 0; i < display_pkg::DIGIT_COUNT; i++) begin
			enb_next[i] = (next_idx != display_pkg::digit_sel_t'(i));
		end
		// Dot marks the mode: digit 0 setup, digit 1 alarm
		case (i_mode)
			clock_pkg::MODE_SETUP: dp_next = (next_idx == 2'd0);
			clock_pkg::MODE_ALARM: dp_next = (next_idx == 2'd1);
			default:               dp_next = 1'b0;
		endcase
	end

	// ----------------------------------------------------------
	// Registered scan state and outputs
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx  <= '0;
			o_seg_enb <= {{(display_pkg::DIGIT_COUNT-1){1'b1}}, 1'b0};
			o_seg_dp  <= 1'b0;
		end else begin
			scan_idx  <= next_idx;
			o_seg_enb <= enb_next;
			o_seg_dp  <= dp_next;
		end
	end

	// Segment pattern of the selected digit
	always_ff @(posedge clk) begin
		o_seg <= i_seg_codes[next_idx];
	end

endmodule

//--- source/digit_encoder.sv
// Digit encoder: splits minutes and seconds into decimal digits and decodes segments
module digit_encoder (
	input  clock_pkg::time_field_t i_min,
	input  clock_pkg::time_field_t i_sec,
	output display_pkg::segment_t  o_seg_codes [display_pkg::DIGIT_COUNT]
);

	// Decimal digits of each field
	display_pkg::digit_t sec_ones;
	display_pkg::digit_t sec_tens;
	display_pkg::digit_t min_ones;
	display_pkg::digit_t min_tens;

	// ----------------------------------------------------------
	// Tens and ones split
	// ----------------------------------------------------------

	// Fields top out at 59, so tens fit in four bits
	always_comb begin
		sec_tens = display_pkg::digit_t'(i_sec / 10);
		sec_ones = display_pkg::digit_t'(i_sec % 10);
		min_tens = display_pkg::digit_t'(i_min / 10);
		min_ones = display_pkg::digit_t'(i_min % 10);
	end

	// ----------------------------------------------------------
	// Segment decode
	// ----------------------------------------------------------

	// Rightmost digit first
	always_comb begin
		o_seg_codes[0] = display_pkg::seg_of_digit(sec_ones);
		o_seg_codes[1] = display_pkg::seg_of_digit(sec_tens);
		o_seg_codes[2] = display_pkg::seg_of_digit(min_ones);
		o_seg_codes[3] = display_pkg::seg_of_digit(min_tens);
	end

endmodule

//--- source/time_keeper.sv
// Time keeper: time and alarm counters, minute carry, display select and alarm latch
module time_keeper (
	input  logic                   clk,
	input  logic                   rst_n,
	input  clock_pkg::mode_t       i_mode,
	input  logic                   i_alarm_en,
	input  logic                   i_sec_run,
	input  logic                   i_set_sec,
	input  logic                   i_set_min,
	input  logic                   i_set_alarm_sec,
	input  logic                   i_set_alarm_min,
	output clock_pkg::time_field_t o_show_min,
	output clock_pkg::time_field_t o_show_sec,
	output logic                   o_alarm
);

	// Running time
	clock_pkg::time_field_t sec_q;
	clock_pkg::time_field_t min_q;
	// Alarm setting
	clock_pkg::time_field_t alarm_sec_q;
	clock_pkg::time_field_t alarm_min_q;

	logic sec_carry;
	logic time_match;

	// Modulo-60 increment
	function automatic clock_pkg::time_field_t next_field(input clock_pkg::time_field_t value);
		clock_pkg::time_field_t next;
		if (value >= clock_pkg::FIELD_MAX) begin
			next = '0;
		end else begin
			next = value + 1'b1;
		end
		return next;
	endfunction

	// Carry only from a running tick, never from a set step
	assign sec_carry = i_sec_run && (sec_q == clock_pkg::FIELD_MAX);

	// ----------------------------------------------------------
	// Field counters
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_q       <= '0;
			min_q       <= '0;
			alarm_sec_q <= '0;
			alarm_min_q <= '0;
		end else begin
			if (i_sec_run || i_set_sec) begin
				sec_q <= next_field(sec_q);
			end
			if (i_set_min || sec_carry) begin
				min_q <= next_field(min_q);
			end
			// Alarm fields move on their own steps only
			if (i_set_alarm_sec) begin
				alarm_sec_q <= next_field(alarm_sec_q);
			end
			if (i_set_alarm_min) begin
				alarm_min_q <= next_field(alarm_min_q);
			end
		end
	end

	// ----------------------------------------------------------
	// Alarm latch
	// ----------------------------------------------------------
	assign time_match = (sec_q == alarm_sec_q) && (min_q == alarm_min_q);

	// Set on match, hold while enabled, clear when disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en && (o_alarm || time_match);
		end
	end

	// Alarm mode shows the alarm setting
	assign o_show_sec = (i_mode == clock_pkg::MODE_ALARM) ? alarm_sec_q : sec_q;
	assign o_show_min = (i_mode == clock_pkg::MODE_ALARM) ? alarm_min_q : min_q;

endmodule

//--- source/clock_controller.sv
// Clock controller: mode, position and alarm-enable state, routes run and step strobes
module clock_controller (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_sec_tick,
	input  logic                 i_press_mode,
	input  logic                 i_press_pos,
	input  logic                 i_press_step,
	input  logic                 i_press_alarm,
	output clock_pkg::mode_t     o_mode,
	output clock_pkg::position_t o_position,
	output logic                 o_alarm_en,
	output logic                 o_sec_run,
	output logic                 o_set_sec,
	output logic                 o_set_min,
	output logic                 o_set_alarm_sec,
	output logic                 o_set_alarm_min
);

	// Step press qualified by mode
	logic step_setup;
	logic step_alarm;

	// ----------------------------------------------------------
	// Control state
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_position <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			// Mode ring clock -> setup -> alarm -> clock
			if (i_press_mode) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			// Position flips between seconds and minutes
			if (i_press_pos) begin
				o_position <= (o_position == clock_pkg::POS_SEC) ?
					clock_pkg::POS_MIN : clock_pkg::POS_SEC;
			end
			if (i_press_alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// ----------------------------------------------------------
	// Strobe routing
	// ----------------------------------------------------------

	// Time frozen while in setup
	assign o_sec_run = i_sec_tick &&
		((o_mode == clock_pkg::MODE_CLOCK) || (o_mode == clock_pkg::MODE_ALARM));

	// Steps ignored in clock mode
	assign step_setup = i_press_step && (o_mode == clock_pkg::MODE_SETUP);
	assign step_alarm = i_press_step && (o_mode == clock_pkg::MODE_ALARM);

	// Position picks the field
	assign o_set_sec       = step_setup && (o_position == clock_pkg::POS_SEC);
	assign o_set_min       = step_setup && (o_position == clock_pkg::POS_MIN);
	assign o_set_alarm_sec = step_alarm && (o_position == clock_pkg::POS_SEC);
	assign o_set_alarm_min = step_alarm && (o_position == clock_pkg::POS_MIN);

endmodule

//--- source/switch_conditioner.sv
// Switch conditioner: synchronizes and debounces active-low switches into press pulses
module switch_conditioner #(
	parameter int SWITCH_COUNT = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_sample,
	input  logic [SWITCH_COUNT-1:0] i_sw_n,
	output logic [SWITCH_COUNT-1:0] o_press
);

	// Two-flop synchronizer, raw active-low levels
	logic [SWITCH_COUNT-1:0] sync_q1;
	logic [SWITCH_COUNT-1:0] sync_q2;
	// Sample history, 1 means pressed
	logic [SWITCH_COUNT-1:0] hist_q1;
	logic [SWITCH_COUNT-1:0] hist_q2;
	// Debounced state
	logic [SWITCH_COUNT-1:0] accepted;

	// ----------------------------------------------------------
	// Synchronizer and sampled history
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// Released is high on the pins
			sync_q1 <= '1;
			sync_q2 <= '1;
			hist_q1 <= '0;
			hist_q2 <= '0;
		end else begin
			sync_q1 <= i_sw_n;
			sync_q2 <= sync_q1;
			// Shift only on the sample strobe
			if (i_sample) begin
				hist_q1 <= ~sync_q2;
				hist_q2 <= hist_q1;
			end
		end
	end

	// Accept on two pressed samples, drop on two released samples
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			accepted <= '0;
		end else begin
			accepted <= (accepted | (hist_q1 & hist_q2)) & (hist_q1 | hist_q2);
		end
	end

	// Single cycle pulse on the released to pressed turn
	assign o_press = hist_q1 & hist_q2 & ~accepted;

endmodule

//--- source/tick_gen.sv
// Tick generator: one-cycle enable strobe every DIVISOR clocks
module tick_gen #(
	parameter int DIVISOR = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	// Counter just wide enough for DIVISOR-1
	localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIVISOR - 1);

	logic [CNT_W-1:0] cnt;

	// ----------------------------------------------------------
	// Wrapping period counter
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			// End of period, start over
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Strobe on the last count of each period
	// First one lands DIVISOR cycles after reset
	assign o_tick = (cnt == CNT_LAST);

endmodule

//--- source/display_pkg.sv
// Display package: digit count, segment types and the seven-segment decode table
package display_pkg;

	// Scanned digits: sec ones, sec tens, min ones, min tens
	localparam int DIGIT_COUNT = 4;

	// One decimal digit
	typedef logic [3:0] digit_t;

	// Segments a..g on bits 6..0, active high
	typedef logic [6:0] segment_t;

	// Scan index
	typedef logic [1:0] digit_sel_t;

	// All segments off
	localparam segment_t SEG_BLANK = 7'b000_0000;

	// ----------------------------------------------------------
	// Digit to segment decode
	// ----------------------------------------------------------
	function automatic segment_t seg_of_digit(input digit_t digit);
		segment_t seg;
		case (digit)
			4'd0:    seg = 7'b111_1110;
			4'd1:    seg = 7'b011_0000;
			4'd2:    seg = 7'b110_1101;
			4'd3:    seg = 7'b111_1001;
			4'd4:    seg = 7'b011_0011;
			4'd5:    seg = 7'b101_1011;
			4'd6:    seg = 7'b101_1111;
			4'd7:    seg = 7'b111_0000;
			4'd8:    seg = 7'b111_1111;
			4'd9:    seg = 7'b111_0011;
			// Values above 9 stay dark
			default: seg = SEG_BLANK;
		endcase
		return seg;
	endfunction

endpackage

//--- source/clock_pkg.sv
// Clock package: time field type, field limit, mode and position codes
package clock_pkg;

	// ----------------------------------------------------------
	// Time fields
	// ----------------------------------------------------------

	// One minutes or seconds value, 0 to 59
	typedef logic [5:0] time_field_t;

	// Last value before wrap
	localparam time_field_t FIELD_MAX = 6'd59;

	// ----------------------------------------------------------
	// Control codes
	// ----------------------------------------------------------

	// Operating mode, stepped by the mode switch
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,
		MODE_ALARM = 2'b10
	} mode_t;

	// Field picked by the position switch
	typedef enum logic {
		POS_SEC = 1'b0,
		POS_MIN = 1'b1
	} position_t;

endpackage
